//--- sim/bus_trace.txt
// addr we data mask | ram_oe ram_we io_oe pia1 pia2 via crtc a10 a11 a15 a16
// One line per CPU cycle, all values in hex, expected strobes are seen at state 63
0000 0 00 3  1 0 0 0 0 0 0 0 0 0 0
1234 1 5A 3  0 1 0 0 0 0 0 0 0 0 0
7C00 0 00 3  1 0 0 0 0 0 0 1 1 0 0
7FFF 1 A5 0  0 1 0 0 0 0 0 1 1 0 0
9000 1 FF 3  0 0 0 0 0 0 0 0 0 1 0
C000 1 00 3  0 0 0 0 0 0 0 0 0 1 0
FFFF 1 12 3  0 0 0 0 0 0 0 1 1 1 0
D000 0 00 3  1 0 0 0 0 0 0 0 0 1 0
FFF0 0 00 3  0 0 0 0 0 0 0 1 1 1 0
E810 0 00 3  0 0 1 1 0 0 0 0 1 1 0
E820 0 00 3  0 0 1 0 1 0 0 0 1 1 0
E840 1 3C 3  0 0 1 0 0 1 0 0 1 1 0
E880 0 00 3  0 0 1 0 0 0 1 0 1 1 0
E80F 0 00 3  0 0 1 0 0 0 0 0 1 1 0
8C00 0 00 3  1 0 0 0 0 0 0 1 1 1 0
8C00 0 00 1  1 0 0 0 0 0 0 1 0 1 0
8C00 0 00 2  1 0 0 0 0 0 0 0 1 1 0
8C00 1 77 0  0 1 0 0 0 0 0 0 0 1 0
8400 0 00 2  1 0 0 0 0 0 0 0 0 1 0
FFF0 1 88 3  0 0 0 0 0 0 0 1 1 1 0
8C00 0 00 3  1 0 0 0 0 0 0 1 1 0 1
8C00 0 00 0  1 0 0 0 0 0 0 1 1 0 1
C000 1 11 3  0 1 0 0 0 0 0 0 0 1 1
9000 1 22 3  0 1 0 0 0 0 0 0 0 0 1
E810 0 00 3  0 0 1 1 0 0 0 0 1 1 0
1000 0 00 3  1 0 0 0 0 0 0 0 0 0 0
FFF0 0 00 3  0 0 0 0 0 0 0 1 1 1 1
FFF0 1 87 3  0 0 0 0 0 0 0 1 1 1 1
A000 1 33 3  0 0 0 0 0 0 0 0 0 1 1
F000 1 44 3  0 0 0 0 0 0 0 0 0 0 1
B800 0 00 3  1 0 0 0 0 0 0 0 1 1 1
7000 1 55 3  0 1 0 0 0 0 0 0 0 0 0
FFF0 1 00 3  0 0 0 0 0 0 0 1 1 0 1
9000 1 66 3  0 0 0 0 0 0 0 0 0 1 0
8800 0 00 1  1 0 0 0 0 0 0 0 0 1 0

//--- src.f
logic/pet_bus_pkg.sv
logic/bus_timing.sv
logic/address_decoder.sv
logic/bus_drive.sv
logic/pet_bus_top.sv
sim/pet_bus_chk.sv
sim/pet_bus_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --assert --timescale 1ns/1ps -j 0
TOP       = pet_bus_tb
FILELIST  = src.f

OBJ_DIR   = obj_dir
BIN       = $(OBJ_DIR)/V$(TOP)
SOURCES   = $(shell grep -v '^+' $(FILELIST))
TRACE     = sim/bus_trace.txt

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Fails unless the pass line shows up in the output
run: $(BIN) $(TRACE)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx 'TEST OK'

clean:
	rm -rf $(OBJ_DIR)

//--- sim/pet_bus_tb.sv
// Reads sim/bus_trace.txt from the run directory, one line per CPU cycle and at most 64 lines
`default_nettype none

module pet_bus_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD      = 40;
    localparam int DRIVE_DELAY     = 5;
    localparam int RESET_CYCLES    = 3;
    localparam int FIELDS          = 15;  // Columns per trace line
    localparam int STIM_FIELDS     = 4;   // Address, we, data, mask
    localparam int MAX_LINES       = 64;
    localparam int WATCHDOG_MARGIN = 4;   // Spare CPU cycles

    localparam int BE_STATE    = pet_bus_pkg::BE_START;
    localparam int LAST_STATE  = pet_bus_pkg::CYCLE_STATES - 1;
    localparam int BE_CLOCKS   = pet_bus_pkg::CYCLE_STATES - pet_bus_pkg::BE_START;
    localparam int PHI2_CLOCKS = pet_bus_pkg::CYCLE_STATES - pet_bus_pkg::PHI2_START;

    // Expected outputs of one trace line in file column order
    typedef struct packed {
        logic ram_oe;
        logic ram_we;
        logic io_oe;
        logic pia1_cs;
        logic pia2_cs;
        logic via_cs;
        logic crtc_cs;
        logic a10;
        logic a11;
        logic a15;
        logic a16;
    } strobes_t;

    localparam int STROBE_BITS = $bits(strobes_t);

    logic        sys_clock;
    logic        rst_n;
    logic [15:0] cpu_addr;
    logic        cpu_we;
    logic [7:0]  cpu_data;
    logic [1:0]  vram_mask;
    logic        cpu_be;
    logic        cpu_clock;
    strobes_t    act;

    logic [19:0] trace_mem [MAX_LINES * FIELDS];
    int          trace_lines;
    logic        trace_ready = 1'b0;

    int cyc_state;      // Reference copy of the 64-state cycle counter
    int be_high;
    int phi2_high;
    int output_errors = 0;
    int duty_errors   = 0;
    int other_errors  = 0;

    pet_bus_top uut (
        .sys_clock_i    (sys_clock),
        .rst_ni         (rst_n),
        .cpu_addr_i     (cpu_addr),
        .cpu_we_i       (cpu_we),
        .cpu_data_i     (cpu_data),
        .vram_mask_i    (vram_mask),
        .cpu_be_o       (cpu_be),
        .cpu_clock_o    (cpu_clock),
        .ram_oe_o       (act.ram_oe),
        .ram_we_o       (act.ram_we),
        .io_oe_o        (act.io_oe),
        .pia1_cs_o      (act.pia1_cs),
        .pia2_cs_o      (act.pia2_cs),
        .via_cs_o       (act.via_cs),
        .crtc_cs_o      (act.crtc_cs),
        .ram_addr_a10_o (act.a10),
        .ram_addr_a11_o (act.a11),
        .ram_addr_a15_o (act.a15),
        .ram_addr_a16_o (act.a16)
    );

    bind bus_drive pet_bus_chk u_chk (
        .sys_clock_i (sys_clock_i),
        .rst_ni      (rst_ni),
        .decode_i    (decode_i),
        .ram_oe_i    (ram_oe_o),
        .ram_we_i    (ram_we_o),
        .io_oe_i     (io_oe_o),
        .pia1_cs_i   (pia1_cs_o),
        .pia2_cs_i   (pia2_cs_o),
        .via_cs_i    (via_cs_o),
        .crtc_cs_i   (crtc_cs_o)
    );

    always #(CLK_PERIOD / 2) sys_clock = ~sys_clock;

    always @(posedge sys_clock or negedge rst_n) begin
        if (!rst_n) begin
            cyc_state <= 0;
        end else begin
            cyc_state <= (cyc_state + 1) % pet_bus_pkg::CYCLE_STATES;
        end
    end

    // Count bus enable and CPU clock highs over each full CPU cycle
    always @(negedge sys_clock) begin
        if (rst_n) begin
            if (cyc_state == 0) begin
                be_high   = 0;
                phi2_high = 0;
            end
            if (cpu_be) be_high++;
            if (cpu_clock) phi2_high++;
            if (cyc_state == LAST_STATE) begin
                assert (be_high == BE_CLOCKS) else begin
                    $display("cpu_be_o was high for %0d clocks of a CPU cycle instead of %0d",
                             be_high, BE_CLOCKS);
                    duty_errors++;
                end
                assert (phi2_high == PHI2_CLOCKS) else begin
                    $display("cpu_clock_o was high for %0d clocks of a CPU cycle instead of %0d",
                             phi2_high, PHI2_CLOCKS);
                    duty_errors++;
                end
            end
        end
    end

    task automatic load_trace();
        int i;
        for (i = 0; i < MAX_LINES * FIELDS; i++) begin
            trace_mem[i] = {4'hF, 16'(i)};  // Top nibble marks words past the end of the file
        end
        $readmemh("sim/bus_trace.txt", trace_mem);
        trace_lines = 0;
        while (trace_lines < MAX_LINES && trace_mem[trace_lines * FIELDS][19:16] == 4'h0) begin
            trace_lines++;
        end
        if (trace_lines == 0) begin
            $display("No stimulus lines could be read from sim/bus_trace.txt");
            other_errors++;
        end
        trace_ready = 1'b1;
    endtask

    task automatic wait_for_state(input int target);
        do begin
            @(posedge sys_clock);
            #DRIVE_DELAY;   // Outputs settled past the edge
        end while (cyc_state != target);
    endtask

    task automatic apply_line(input int line);
        int base;
        base      = line * FIELDS;
        cpu_addr  = trace_mem[base][15:0];
        cpu_we    = trace_mem[base + 1][0];
        cpu_data  = trace_mem[base + 2][7:0];
        vram_mask = trace_mem[base + 3][1:0];
    endtask

    task automatic compare_output(input string name, input int line,
                                  input logic expected, input logic actual);
        assert (actual === expected) else begin
            $display("MISMATCH line %0d %s expected 0x%0h actual 0x%0h",
                     line, name, expected, actual);
            output_errors++;
        end
    endtask

    task automatic check_line(input int line);
        int       base;
        int       f;
        strobes_t exp_s;
        base = line * FIELDS + STIM_FIELDS;
        for (f = 0; f < STROBE_BITS; f++) begin
            exp_s[STROBE_BITS - 1 - f] = trace_mem[base + f][0];
        end
        compare_output("cpu_be_o", line, 1'b1, cpu_be);
        compare_output("cpu_clock_o", line, 1'b1, cpu_clock);
        compare_output("ram_oe_o", line, exp_s.ram_oe, act.ram_oe);
        compare_output("ram_we_o", line, exp_s.ram_we, act.ram_we);
        compare_output("io_oe_o", line, exp_s.io_oe, act.io_oe);
        compare_output("pia1_cs_o", line, exp_s.pia1_cs, act.pia1_cs);
        compare_output("pia2_cs_o", line, exp_s.pia2_cs, act.pia2_cs);
        compare_output("via_cs_o", line, exp_s.via_cs, act.via_cs);
        compare_output("crtc_cs_o", line, exp_s.crtc_cs, act.crtc_cs);
        compare_output("ram_addr_a10_o", line, exp_s.a10, act.a10);
        compare_output("ram_addr_a11_o", line, exp_s.a11, act.a11);
        compare_output("ram_addr_a15_o", line, exp_s.a15, act.a15);
        compare_output("ram_addr_a16_o", line, exp_s.a16, act.a16);
    endtask

    initial begin : stimulus
        int line;
        int assert_errors;
        sys_clock = 1'b0;
        rst_n     = 1'b0;
        cpu_addr  = '0;
        cpu_we    = 1'b0;
        cpu_data  = '0;
        vram_mask = '0;
        load_trace();
        repeat (RESET_CYCLES) @(posedge sys_clock);
        #DRIVE_DELAY;
        rst_n = 1'b1;
        for (line = 0; line < trace_lines; line++) begin
            wait_for_state(BE_STATE);     // CPU slot opens
            apply_line(line);
            wait_for_state(LAST_STATE);   // Strobes of state 61 visible here
            check_line(line);
        end
        assert_errors = uut.u_drive.u_chk.failures;
        $display("Errors: outputs %0d, duty cycle %0d, assertions %0d, other %0d",
                 output_errors, duty_errors, assert_errors, other_errors);
        if (output_errors + duty_errors + assert_errors + other_errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        int limit_ns;
        wait (trace_ready);
        limit_ns = ((trace_lines + WATCHDOG_MARGIN) * pet_bus_pkg::CYCLE_STATES + RESET_CYCLES)
                   * CLK_PERIOD;
        #(limit_ns);
        $display("Timeout: the trace did not finish within %0d ns", limit_ns);
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- sim/pet_bus_chk.sv
// Bound into bus_drive where strobe outputs are checked against the decode of the previous clock
`default_nettype none

module pet_bus_chk (
    input wire logic                  sys_clock_i,
    input wire logic                  rst_ni,
    input wire pet_bus_pkg::decode_t  decode_i,
    input wire logic                  ram_oe_i,
    input wire logic                  ram_we_i,
    input wire logic                  io_oe_i,
    input wire logic                  pia1_cs_i,
    input wire logic                  pia2_cs_i,
    input wire logic                  via_cs_i,
    input wire logic                  crtc_cs_i
);

    timeunit 1ns;
    timeprecision 1ps;

    logic any_strobe;
    int   failures = 0;  // Failed assertion count

    assign any_strobe = ram_oe_i || ram_we_i || io_oe_i ||
                        pia1_cs_i || pia2_cs_i || via_cs_i || crtc_cs_i;

    // RAM and I/O never drive the data bus together
    assert property (@(posedge sys_clock_i) disable iff (!rst_ni)
        !(ram_oe_i && io_oe_i))
    else begin
        $error("ram_oe and io_oe are high at the same time");
        failures++;
    end

    assert property (@(posedge sys_clock_i) disable iff (!rst_ni)
        !decode_i.phase.be |=> !any_strobe)
    else begin
        $error("A strobe went high outside the CPU bus slot");
        failures++;
    end

    assert property (@(posedge sys_clock_i) disable iff (!rst_ni)
        decode_i.is_readonly |=> !ram_we_i)
    else begin
        $error("ram_we went high for a read-only address");
        failures++;
    end

endmodule

`default_nettype wire

//--- logic/pet_bus_top.sv
// Strobes lag the CPU address by two clocks; cpu_be_o and cpu_clock_o come straight from timing
`default_nettype none

module pet_bus_top (
    input  wire logic                                   sys_clock_i,
    input  wire logic                                   rst_ni,
    input  wire logic [pet_bus_pkg::CPU_ADDR_WIDTH-1:0] cpu_addr_i,
    input  wire logic                                   cpu_we_i,
    input  wire logic [pet_bus_pkg::DATA_WIDTH-1:0]     cpu_data_i,
    input  wire logic [1:0]                             vram_mask_i,
    output logic                                        cpu_be_o,
    output logic                                        cpu_clock_o,
    output logic                                        ram_oe_o,
    output logic                                        ram_we_o,
    output logic                                        io_oe_o,
    output logic                                        pia1_cs_o,
    output logic                                        pia2_cs_o,
    output logic                                        via_cs_o,
    output logic                                        crtc_cs_o,
    output logic                                        ram_addr_a10_o,
    output logic                                        ram_addr_a11_o,
    output logic                                        ram_addr_a15_o,
    output logic                                        ram_addr_a16_o
);

    pet_bus_pkg::bus_phase_t phase;
    pet_bus_pkg::decode_t    decode;

    // CPU sees the phase with no extra delay
    assign cpu_be_o    = phase.be;
    assign cpu_clock_o = phase.phi2;

    bus_timing u_timing (
        .sys_clock_i (sys_clock_i),
        .rst_ni      (rst_ni),
        .phase_o     (phase)
    );

    address_decoder u_decoder (
        .sys_clock_i (sys_clock_i),
        .rst_ni      (rst_ni),
        .phase_i     (phase),
        .cpu_addr_i  (cpu_addr_i),   // Flat vector into the address union
        .cpu_we_i    (cpu_we_i),
        .cpu_data_i  (cpu_data_i),
        .vram_mask_i (vram_mask_i),
        .decode_o    (decode)
    );

    bus_drive u_drive (
        .sys_clock_i    (sys_clock_i),
        .rst_ni         (rst_ni),
        .decode_i       (decode),
        .ram_oe_o       (ram_oe_o),
        .ram_we_o       (ram_we_o),
        .io_oe_o        (io_oe_o),
        .pia1_cs_o      (pia1_cs_o),
        .pia2_cs_o      (pia2_cs_o),
        .via_cs_o       (via_cs_o),
        .crtc_cs_o      (crtc_cs_o),
        .ram_addr_a10_o (ram_addr_a10_o),
        .ram_addr_a11_o (ram_addr_a11_o),
        .ram_addr_a15_o (ram_addr_a15_o),
        .ram_addr_a16_o (ram_addr_a16_o)
    );

endmodule

`default_nettype wire

//--- logic/bus_drive.sv
// Outputs are registered one clock after the decode; all strobes are qualified by the decoded be
`default_nettype none

module bus_drive (
    input  wire logic                   sys_clock_i,
    input  wire logic                   rst_ni,
    input  wire pet_bus_pkg::decode_t   decode_i,
    output logic                        ram_oe_o,
    output logic                        ram_we_o,
    output logic                        io_oe_o,
    output logic                        pia1_cs_o,
    output logic                        pia2_cs_o,
    output logic                        via_cs_o,
    output logic                        crtc_cs_o,
    output logic                        ram_addr_a10_o,
    output logic                        ram_addr_a11_o,
    output logic                        ram_addr_a15_o,
    output logic                        ram_addr_a16_o
);

    logic be;
    logic rd_en;
    logic wr_en;

    assign be    = decode_i.phase.be;
    assign rd_en = be && !decode_i.we;
    assign wr_en = be && decode_i.we && decode_i.phase.phi2;  // Write only in the PHI2 half

    always_ff @(posedge sys_clock_i or negedge rst_ni) begin
        if (!rst_ni) begin
            ram_oe_o       <= 1'b0;
            ram_we_o       <= 1'b0;
            io_oe_o        <= 1'b0;
            pia1_cs_o      <= 1'b0;
            pia2_cs_o      <= 1'b0;
            via_cs_o       <= 1'b0;
            crtc_cs_o      <= 1'b0;
            ram_addr_a10_o <= 1'b0;
            ram_addr_a11_o <= 1'b0;
            ram_addr_a15_o <= 1'b0;
            ram_addr_a16_o <= 1'b0;
        end else begin
            // RAM strobes
            ram_oe_o <= rd_en && decode_i.ram_en;
            ram_we_o <= wr_en && decode_i.ram_en && !decode_i.is_readonly;

            // I/O and chip selects
            io_oe_o   <= be && decode_i.io_en;
            pia1_cs_o <= be && decode_i.pia1_en;
            pia2_cs_o <= be && decode_i.pia2_en;
            via_cs_o  <= be && decode_i.via_en;
            crtc_cs_o <= be && decode_i.crtc_en;

            // Address lines, already masked and banked
            ram_addr_a10_o <= decode_i.a10;
            ram_addr_a11_o <= decode_i.a11;
            ram_addr_a15_o <= decode_i.a15;
            ram_addr_a16_o <= decode_i.a16;
        end
    end

endmodule

`default_nettype wire

//--- logic/address_decoder.sv
// Decode is one clock behind its inputs; a $FFF0 write applies to decodes sampled after the strobe
`default_nettype none

module address_decoder (
    input  wire logic                                   sys_clock_i,
    input  wire logic                                   rst_ni,
    input  wire pet_bus_pkg::bus_phase_t                phase_i,
    input  wire pet_bus_pkg::cpu_addr_u                 cpu_addr_i,
    input  wire logic                                   cpu_we_i,
    input  wire logic [pet_bus_pkg::DATA_WIDTH-1:0]     cpu_data_i,
    input  wire logic [1:0]                             vram_mask_i,
    output pet_bus_pkg::decode_t                        decode_o
);

    logic [pet_bus_pkg::DATA_WIDTH-1:0] exp_q;  // Expansion control register

    logic is_io;
    logic is_exp_reg;
    logic exp_on;
    logic remap;
    logic exp_wr;

    pet_bus_pkg::decode_t decode_d;

    assign is_io      = (cpu_addr_i.io.page == pet_bus_pkg::IO_PAGE);
    assign is_exp_reg = (cpu_addr_i.flat == pet_bus_pkg::EXP_REG_ADDR);
    assign exp_on     = exp_q[pet_bus_pkg::EXP_ENABLE_BIT];

    // Upper 32 KB goes to the second 64 KB, I/O page stays put
    assign remap = exp_on && cpu_addr_i.flat[15] && !is_io;

    // CPU write lands on the data strobe
    assign exp_wr = phase_i.strobe && cpu_we_i && is_exp_reg;

    always_ff @(posedge sys_clock_i or negedge rst_ni) begin
        if (!rst_ni) begin
            exp_q <= '0;
        end else if (exp_wr) begin
            exp_q <= cpu_data_i;
        end
    end

    always_comb begin
        decode_d = '0;

        // I/O page, each device on its own select line
        decode_d.io_en   = is_io;
        decode_d.pia1_en = is_io && cpu_addr_i.io.pia1;
        decode_d.pia2_en = is_io && cpu_addr_i.io.pia2;
        decode_d.via_en  = is_io && cpu_addr_i.io.via;
        decode_d.crtc_en = is_io && cpu_addr_i.io.crtc;

        // RAM answers everywhere else
        decode_d.ram_en = !is_io && !is_exp_reg;

        // Video RAM only exists in the unexpanded map
        decode_d.is_vram = !exp_on &&
                           (cpu_addr_i.flat[15:12] == pet_bus_pkg::VRAM_PAGE);

        // Wrap video memory by masking A10/A11
        decode_d.a10 = cpu_addr_i.flat[10] && (!decode_d.is_vram || vram_mask_i[0]);
        decode_d.a11 = cpu_addr_i.flat[11] && (!decode_d.is_vram || vram_mask_i[1]);

        if (remap) begin
            decode_d.a16 = 1'b1;
            if (cpu_addr_i.flat[14]) begin  // $C000-$FFFF
                decode_d.a15         = exp_q[pet_bus_pkg::EXP_BANK_HI_BIT];
                decode_d.is_readonly = exp_q[pet_bus_pkg::EXP_WP_HI_BIT];
            end else begin                  // $8000-$BFFF
                decode_d.a15         = exp_q[pet_bus_pkg::EXP_BANK_LO_BIT];
                decode_d.is_readonly = exp_q[pet_bus_pkg::EXP_WP_LO_BIT];
            end
        end else begin
            decode_d.a16         = 1'b0;
            decode_d.a15         = cpu_addr_i.flat[15];
            decode_d.is_readonly = !is_io && (cpu_addr_i.flat >= pet_bus_pkg::ROM_BASE);
        end

        decode_d.we    = cpu_we_i;
        decode_d.phase = phase_i;  // Travels with its address
    end

    always_ff @(posedge sys_clock_i or negedge rst_ni) begin
        if (!rst_ni) begin
            decode_o <= '0;
        end else begin
            decode_o <= decode_d;
        end
    end

endmodule

`default_nettype wire

//--- logic/bus_timing.sv
// Free-running from reset; CYCLE_STATES need not be a power of two, phase bits are registered
`default_nettype none

module bus_timing (
    input  wire logic              sys_clock_i,
    input  wire logic              rst_ni,
    output pet_bus_pkg::bus_phase_t phase_o
);

    localparam int SW = pet_bus_pkg::STATE_WIDTH;

    localparam logic [SW-1:0] LAST_STATE   = SW'(pet_bus_pkg::CYCLE_STATES - 1);
    localparam logic [SW-1:0] BE_STATE     = SW'(pet_bus_pkg::BE_START);
    localparam logic [SW-1:0] PHI2_STATE   = SW'(pet_bus_pkg::PHI2_START);
    localparam logic [SW-1:0] STROBE_STATE = SW'(pet_bus_pkg::STROBE_STATE);

    logic [SW-1:0] state_q;
    logic [SW-1:0] state_d;

    pet_bus_pkg::bus_phase_t phase_d;

    // Next state, wrapping at the end of the CPU cycle
    always_comb begin
        if (state_q == LAST_STATE) begin
            state_d = '0;
        end else begin
            state_d = state_q + 1'b1;
        end
    end

    // Decode from the next state so the registered phase lines up with state_q
    always_comb begin
        phase_d.be     = (state_d >= BE_STATE);
        phase_d.phi2   = (state_d >= PHI2_STATE);
        phase_d.strobe = (state_d == STROBE_STATE);
    end

    always_ff @(posedge sys_clock_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= '0;
            phase_o <= '0;   // State 0 has all phase bits low
        end else begin
            state_q <= state_d;
            phase_o <= phase_d;  // Glitch-free outputs
        end
    end

endmodule

`default_nettype wire

//--- logic/pet_bus_pkg.sv
// Assumes a 64 MHz system clock, 64 states per 1 MHz CPU cycle and the PET 4032/8032 memory map
`default_nettype none

package pet_bus_pkg;

    // Bus widths
    localparam int CPU_ADDR_WIDTH = 16;
    localparam int DATA_WIDTH     = 8;

    // Cycle timing, counted in system clocks within one CPU cycle
    localparam int CYCLE_STATES = 64;
    localparam int STATE_WIDTH  = $clog2(CYCLE_STATES);
    localparam int BE_START     = 16;   // CPU owns the bus from here to the last state
    localparam int PHI2_START   = 32;   // CPU clock rises
    localparam int STROBE_STATE = 62;   // Data valid, one clock wide

    // Memory map
    localparam logic [7:0] IO_PAGE   = 8'hE8;  // $E800-$E8FF
    localparam logic [3:0] VRAM_PAGE = 4'h8;   // $8000-$8FFF

    localparam logic [CPU_ADDR_WIDTH-1:0] ROM_BASE     = 16'h9000;
    localparam logic [CPU_ADDR_WIDTH-1:0] EXP_REG_ADDR = 16'hFFF0;

    // Expansion control register at $FFF0
    localparam int EXP_ENABLE_BIT  = 7;
    localparam int EXP_BANK_HI_BIT = 3;  // Bank for $C000-$FFFF
    localparam int EXP_BANK_LO_BIT = 2;  // Bank for $8000-$BFFF
    localparam int EXP_WP_HI_BIT   = 1;
    localparam int EXP_WP_LO_BIT   = 0;

    // Position within the CPU cycle, one bit per bus event
    typedef struct packed {
        logic be;      // CPU drives the bus
        logic phi2;    // CPU clock
        logic strobe;  // Write data sample point
    } bus_phase_t;

    // I/O page layout: one select line per device, low nibble picks the register
    typedef struct packed {
        logic [7:0] page;
        logic       crtc;  // $E880
        logic       via;   // $E840
        logic       pia2;  // $E820
        logic       pia1;  // $E810
        logic [3:0] rs;
    } io_addr_t;

    // Same CPU address, seen flat or as I/O fields
    typedef union packed {
        logic [CPU_ADDR_WIDTH-1:0] flat;
        io_addr_t                  io;
    } cpu_addr_u;

    // One decoded bus access, carried from decoder to drive stage
    typedef struct packed {
        logic       ram_en;
        logic       io_en;
        logic       pia1_en;
        logic       pia2_en;
        logic       via_en;
        logic       crtc_en;
        logic       is_vram;
        logic       is_readonly;
        logic       we;
        logic       a10;    // After video RAM wrap
        logic       a11;
        logic       a15;    // After expansion banking
        logic       a16;
        bus_phase_t phase;
    } decode_t;

endpackage

`default_nettype wire
